/* noc_mesh_pkg.sv */
`default_nettype none

package noc_mesh_pkg;

   ////////////////////////////////////////
   // mesh geometry
   ////////////////////////////////////////

   // five router ports per node
   localparam int NUM_PORTS = 5;

   // 4x4 mesh, two bits per coordinate
   localparam int COORD_W = 2;

   typedef logic [COORD_W-1:0] coord_t;

   ////////////////////////////////////////
   // port numbering
   ////////////////////////////////////////

   // request and grant vectors index by this
   typedef enum logic [2:0] {
      PORT_LOCAL = 3'd0,
      PORT_EAST  = 3'd1,
      PORT_NORTH = 3'd2,
      PORT_WEST  = 3'd3,
      PORT_SOUTH = 3'd4
   } port_e;

   // one bit per port
   typedef logic [NUM_PORTS-1:0] port_vec_t;

endpackage

`default_nettype wire

/* noc_flit_pkg.sv */
`default_nettype none

package noc_flit_pkg;

   ////////////////////////////////////////
   // flit format
   ////////////////////////////////////////

   localparam int FLIT_W = 8;

   // type code in bits 7:6
   typedef enum logic [1:0] {
      FLIT_BODY = 2'b00,
      FLIT_TAIL = 2'b01,
      FLIT_HDR  = 2'b10
   } flit_type_e;

   // header view
   // dest_x in 1:0, dest_y in 3:2, 5:4 unused
   typedef struct packed {
      flit_type_e          ftype;
      logic [1:0]          spare;
      noc_mesh_pkg::coord_t dest_y;
      noc_mesh_pkg::coord_t dest_x;
   } hdr_view_t;

   // body and tail view, six payload bits
   typedef struct packed {
      flit_type_e ftype;
      logic [5:0] payload;
   } body_view_t;

   // same word, decoded by type
   typedef union packed {
      hdr_view_t  hdr;
      body_view_t body;
   } flit_u;

endpackage

`default_nettype wire

/* flit_lane_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one input lane into the output switch
interface flit_lane_if;
   import noc_mesh_pkg::*;
   import noc_flit_pkg::*;

   // buffer holds a flit
   logic      valid;
   flit_u     flit;
   // one-hot output request, zero when empty
   port_vec_t req;
   // flit is a tail, releases the lock
   logic      last;
   // flit taken this cycle
   logic      grant;

   modport port_side (output valid, flit, req, last, input grant);

   modport switch_side (input valid, flit, req, last, output grant);

endinterface

`default_nettype wire

/* node_addr_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module node_addr_reg #(
   parameter noc_mesh_pkg::coord_t RESET_X = '0,
   parameter noc_mesh_pkg::coord_t RESET_Y = '0
) (
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  cfg_wr,
   input  noc_mesh_pkg::coord_t cfg_x,
   input  noc_mesh_pkg::coord_t cfg_y,
   output noc_mesh_pkg::coord_t node_x,
   output noc_mesh_pkg::coord_t node_y
);

   ////////////////////////////////////////
   // node address register
   ////////////////////////////////////////

   // both coordinates load together
   // new address seen by route logic after the write edge
   always_ff @(posedge clk) begin
      if (rst) begin
         // back to the build-time position
         node_x <= RESET_X;
         node_y <= RESET_Y;
      end else if (cfg_wr) begin
         node_x <= cfg_x;
         node_y <= cfg_y;
      end
   end

endmodule

`default_nettype wire

/* route_compute.sv */
`timescale 1ns/1ps
`default_nettype none

module route_compute (
   input  noc_flit_pkg::flit_u     hdr,
   input  noc_mesh_pkg::coord_t    node_x,
   input  noc_mesh_pkg::coord_t    node_y,
   output noc_mesh_pkg::port_vec_t req
);
   import noc_mesh_pkg::*;

   // one extra bit for the sign
   logic signed [COORD_W:0] xdiff;
   logic signed [COORD_W:0] ydiff;

   // destination minus current node
   assign xdiff = $signed({1'b0, hdr.hdr.dest_x}) - $signed({1'b0, node_x});
   assign ydiff = $signed({1'b0, hdr.hdr.dest_y}) - $signed({1'b0, node_y});

   ////////////////////////////////////////
   // xy decision
   ////////////////////////////////////////

   // x first, then y, local when both match
   always_comb begin
      req = '0;
      if (xdiff > 0) begin
         req[PORT_EAST] = 1'b1;
      end else if (xdiff < 0) begin
         req[PORT_WEST] = 1'b1;
      end else if (ydiff > 0) begin
         // y grows southward
         req[PORT_SOUTH] = 1'b1;
      end else if (ydiff < 0) begin
         req[PORT_NORTH] = 1'b1;
      end else begin
         req[PORT_LOCAL] = 1'b1;
      end
   end

endmodule

`default_nettype wire

/* input_port.sv */
`timescale 1ns/1ps
`default_nettype none

module input_port (
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  in_valid,
   input  noc_flit_pkg::flit_u  in_flit,
   input  noc_mesh_pkg::coord_t node_x,
   input  noc_mesh_pkg::coord_t node_y,
   output logic                 busy,
   flit_lane_if.port_side       lane
);
   import noc_mesh_pkg::*;
   import noc_flit_pkg::*;

   logic      full_q;
   flit_u     flit_q;
   port_vec_t route_q;
   port_vec_t rc_req;
   logic      take;

   // route of whatever sits on the input
   // only kept when it is a header
   route_compute u_route (
      .hdr    (in_flit),
      .node_x (node_x),
      .node_y (node_y),
      .req    (rc_req)
   );

   // accept only into an empty buffer, else the flit is dropped
   assign take = in_valid && !full_q;

   ////////////////////////////////////////
   // buffer state and packet route
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         full_q  <= 1'b0;
         route_q <= '0;
      end else begin
         // leaves on valid and grant
         if (full_q && lane.grant) begin
            full_q <= 1'b0;
            // packet done once the tail is out
            if (flit_q.body.ftype == FLIT_TAIL) begin
               route_q <= '0;
            end
         end
         if (take) begin
            full_q <= 1'b1;
            // body and tail reuse the header route
            if (in_flit.hdr.ftype == FLIT_HDR) begin
               route_q <= rc_req;
            end
         end
      end
   end

   // payload register
   always_ff @(posedge clk) begin
      if (take) begin
         flit_q <= in_flit;
      end
   end

   // lane toward the switch
   assign lane.valid = full_q;
   assign lane.flit  = flit_q;
   assign lane.req   = full_q ? route_q : '0;
   assign lane.last  = full_q && (flit_q.body.ftype == FLIT_TAIL);

   assign busy = full_q;

endmodule

`default_nettype wire

/* output_switch.sv */
`timescale 1ns/1ps
`default_nettype none

module output_switch (
   input  wire                                            clk,
   input  wire                                            rst,
   flit_lane_if.switch_side                               lanes [noc_mesh_pkg::NUM_PORTS],
   output noc_mesh_pkg::port_vec_t                        out_valid,
   output noc_flit_pkg::flit_u [noc_mesh_pkg::NUM_PORTS-1:0] out_flit
);
   import noc_mesh_pkg::*;
   import noc_flit_pkg::*;

   localparam int PIDX_W = $clog2(NUM_PORTS);

   // lane copies, indexed by input
   logic      lane_valid [NUM_PORTS];
   port_vec_t lane_req   [NUM_PORTS];
   flit_u     lane_flit  [NUM_PORTS];
   logic      lane_last  [NUM_PORTS];
   port_vec_t in_grant;

   // per output, one bit per input
   port_vec_t          out_gnt [NUM_PORTS];
   logic [PIDX_W-1:0]  src_idx [NUM_PORTS];

   // wormhole state per output
   logic               lock_q  [NUM_PORTS];
   logic [PIDX_W-1:0]  owner_q [NUM_PORTS];
   // last input served
   logic [PIDX_W-1:0]  ptr_q   [NUM_PORTS];

   for (genvar i = 0; i < NUM_PORTS; i++) begin : g_lane
      assign lane_valid[i] = lanes[i].valid;
      assign lane_req[i]   = lanes[i].req;
      assign lane_flit[i]  = lanes[i].flit;
      assign lane_last[i]  = lanes[i].last;
      assign lanes[i].grant = in_grant[i];
   end

   ////////////////////////////////////////
   // allocation
   ////////////////////////////////////////

   always_comb begin
      logic found;
      int   idx;
      found    = 1'b0;
      idx      = 0;
      in_grant = '0;
      for (int o = 0; o < NUM_PORTS; o++) begin
         out_gnt[o] = '0;
         src_idx[o] = owner_q[o];
         if (lock_q[o]) begin
            // locked, only the owner may pass
            if (lane_valid[owner_q[o]] && lane_req[owner_q[o]][o]) begin
               out_gnt[o][owner_q[o]] = 1'b1;
            end
         end else begin
            // round robin, search starts after the pointer
            found = 1'b0;
            for (int k = 1; k <= NUM_PORTS; k++) begin
               idx = (int'(ptr_q[o]) + k) % NUM_PORTS;
               if (!found && lane_valid[idx] && lane_req[idx][o]) begin
                  out_gnt[o][idx] = 1'b1;
                  src_idx[o] = idx[PIDX_W-1:0];
                  found = 1'b1;
               end
            end
         end
         // each input asks for one output only
         in_grant = in_grant | out_gnt[o];
      end
   end

   ////////////////////////////////////////
   // lock and pointer update
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= '0;
         for (int o = 0; o < NUM_PORTS; o++) begin
            lock_q[o]  <= 1'b0;
            owner_q[o] <= '0;
            // first search starts at input 0
            ptr_q[o]   <= PIDX_W'(NUM_PORTS - 1);
         end
      end else begin
         for (int o = 0; o < NUM_PORTS; o++) begin
            out_valid[o] <= |out_gnt[o];
            if (|out_gnt[o]) begin
               ptr_q[o]   <= src_idx[o];
               owner_q[o] <= src_idx[o];
               // hold until the tail goes through
               lock_q[o]  <= !lane_last[src_idx[o]];
            end
         end
      end
   end

   // crossbar into registered outputs
   always_ff @(posedge clk) begin
      for (int o = 0; o < NUM_PORTS; o++) begin
         if (|out_gnt[o]) begin
            out_flit[o] <= lane_flit[src_idx[o]];
         end
      end
   end

endmodule

`default_nettype wire

/* router_top.sv */
`timescale 1ns/1ps
`default_nettype none

module router_top #(
   parameter noc_mesh_pkg::coord_t RESET_X = '0,
   parameter noc_mesh_pkg::coord_t RESET_Y = '0
) (
   input  wire                                                        clk,
   input  wire                                                        rst,
   input  wire                                                        cfg_wr,
   input  noc_mesh_pkg::coord_t                                       cfg_x,
   input  noc_mesh_pkg::coord_t                                       cfg_y,
   input  wire  [noc_mesh_pkg::NUM_PORTS-1:0]                         in_valid,
   input  wire  [noc_mesh_pkg::NUM_PORTS*noc_flit_pkg::FLIT_W-1:0]    in_flit,
   output logic [noc_mesh_pkg::NUM_PORTS-1:0]                         busy,
   output logic [noc_mesh_pkg::NUM_PORTS-1:0]                         out_valid,
   output logic [noc_mesh_pkg::NUM_PORTS*noc_flit_pkg::FLIT_W-1:0]    out_flit
);
   import noc_mesh_pkg::*;
   import noc_flit_pkg::*;

   coord_t node_x;
   coord_t node_y;

   // one lane per input port
   flit_lane_if lane [NUM_PORTS] ();

   ////////////////////////////////////////
   // node address
   ////////////////////////////////////////

   node_addr_reg #(
      .RESET_X (RESET_X),
      .RESET_Y (RESET_Y)
   ) u_addr (
      .clk    (clk),
      .rst    (rst),
      .cfg_wr (cfg_wr),
      .cfg_x  (cfg_x),
      .cfg_y  (cfg_y),
      .node_x (node_x),
      .node_y (node_y)
   );

   // ports in port_e order, local at index 0
   for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in
      input_port u_in (
         .clk      (clk),
         .rst      (rst),
         .in_valid (in_valid[i]),
         .in_flit  (in_flit[i*FLIT_W +: FLIT_W]),
         .node_x   (node_x),
         .node_y   (node_y),
         .busy     (busy[i]),
         .lane     (lane[i])
      );
   end

   ////////////////////////////////////////
   // switch
   ////////////////////////////////////////

   output_switch u_switch (
      .clk       (clk),
      .rst       (rst),
      .lanes     (lane),
      .out_valid (out_valid),
      .out_flit  (out_flit)
   );

endmodule

`default_nettype wire

/* router_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module router_assertions (
   input wire                                               clk,
   input wire                                               rst,
   input noc_mesh_pkg::port_vec_t                           out_valid,
   input noc_mesh_pkg::port_vec_t                           out_gnt [noc_mesh_pkg::NUM_PORTS],
   input noc_mesh_pkg::port_vec_t                           in_grant,
   input noc_mesh_pkg::port_vec_t                           lane_req [noc_mesh_pkg::NUM_PORTS],
   input logic                                              lock_q [noc_mesh_pkg::NUM_PORTS],
   input logic [$clog2(noc_mesh_pkg::NUM_PORTS)-1:0]        owner_q [noc_mesh_pkg::NUM_PORTS]
);
   import noc_mesh_pkg::*;

   // outputs quiet right after reset
   a_quiet_after_rst: assert property (@(posedge clk) rst |=> (out_valid == '0))
      else $error("out_valid high in the cycle after reset");

   for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out
      // at most one input per output
      a_gnt_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(out_gnt[o]))
         else $error("output %0d granted to several inputs", o);

      // wormhole lock, no other requester of this output is let through
      for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in
         a_lock_owner: assert property (@(posedge clk) disable iff (rst)
            (lock_q[o] && (owner_q[o] != i)) |-> !(in_grant[i] && lane_req[i][o]))
            else $error("locked output %0d granted non-owner input %0d", o, i);
      end
   end

endmodule

bind output_switch router_assertions u_assertions (
   .clk       (clk),
   .rst       (rst),
   .out_valid (out_valid),
   .out_gnt   (out_gnt),
   .in_grant  (in_grant),
   .lane_req  (lane_req),
   .lock_q    (lock_q),
   .owner_q   (owner_q)
);

`default_nettype wire

/* tb_router.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_router;
   import noc_mesh_pkg::*;
   import noc_flit_pkg::*;

   localparam coord_t RST_X = 2'd1;
   localparam coord_t RST_Y = 2'd2;
   localparam int MAX_LEN = 16;
   localparam int MAX_CASES = 32;
   // columns per case line
   localparam int COLS = 8;

   logic clk;
   logic rst;
   logic cfg_wr;
   coord_t cfg_x;
   coord_t cfg_y;
   logic [NUM_PORTS-1:0] in_valid;
   logic [NUM_PORTS*FLIT_W-1:0] in_flit;
   logic [NUM_PORTS-1:0] busy;
   logic [NUM_PORTS-1:0] out_valid;
   logic [NUM_PORTS*FLIT_W-1:0] out_flit;

   logic [7:0] case_mem [MAX_CASES*COLS];
   // expected flits per source input
   flit_u flit_buf [NUM_PORTS][MAX_LEN];
   int wr_cnt [NUM_PORTS];
   int rd_cnt [NUM_PORTS];
   int exp_out [NUM_PORTS];
   // source currently streaming on each output, -1 when idle
   int active [NUM_PORTS];
   logic [NUM_PORTS-1:0] prev_busy;
   int cur_x;
   int cur_y;
   int check_cnt;
   int err_cnt;
   int cycle_cnt;
   int cycle_limit;
   logic [31:0] rng = 32'hd9bc_3626;

   router_top #(.RESET_X(RST_X), .RESET_Y(RST_Y)) dut (
      .clk (clk), .rst (rst), .cfg_wr (cfg_wr), .cfg_x (cfg_x), .cfg_y (cfg_y),
      .in_valid (in_valid), .in_flit (in_flit), .busy (busy),
      .out_valid (out_valid), .out_flit (out_flit)
   );

   // 20 ns period
   always #10 clk = ~clk;

   // run limit
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         $display("timeout after %0d cycles, packets never arrived", cycle_cnt);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////

   task automatic check_equal(input string what, input logic [31:0] got, input logic [31:0] exp);
      check_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("Fail at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // x first, then y, local when equal
   function automatic int xy_port(input int nx, input int ny, input int dx, input int dy);
      if (dx > nx) return PORT_EAST;
      if (dx < nx) return PORT_WEST;
      // y grows southward
      if (dy > ny) return PORT_SOUTH;
      if (dy < ny) return PORT_NORTH;
      return PORT_LOCAL;
   endfunction

   function automatic bit pending();
      for (int i = 0; i < NUM_PORTS; i++) begin
         if (rd_cnt[i] < wr_cnt[i]) return 1'b1;
      end
      return 1'b0;
   endfunction

   task automatic apply_reset();
      @(posedge clk);
      rst <= 1'b1;
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      cur_x = RST_X;
      cur_y = RST_Y;
   endtask

   task automatic write_addr(input int x, input int y);
      @(posedge clk);
      cfg_wr <= 1'b1;
      cfg_x <= coord_t'(x);
      cfg_y <= coord_t'(y);
      @(posedge clk);
      cfg_wr <= 1'b0;
      cur_x = x;
      cur_y = y;
   endtask

   // header, then bodies, tail last; payload from xorshift
   task automatic build_packet(input int src, input int dx, input int dy, input int len);
      flit_u f;
      for (int k = 0; k < len; k++) begin
         rng = xorshift32(rng);
         if (k == 0) begin
            f.hdr.ftype = FLIT_HDR;
            f.hdr.spare = rng[1:0];
            f.hdr.dest_y = coord_t'(dy);
            f.hdr.dest_x = coord_t'(dx);
         end else begin
            f.body.ftype = (k == len - 1) ? FLIT_TAIL : FLIT_BODY;
            f.body.payload = rng[5:0];
         end
         flit_buf[src][k] = f;
      end
      rd_cnt[src] = 0;
      wr_cnt[src] = len;
   endtask

   // checks the line against the current address and the xy rule
   task automatic prepare_case(input int c, output int src, output int len, output int exp);
      int b;
      int dx;
      int dy;
      b = c * COLS;
      src = case_mem[b+3];
      dx = case_mem[b+4];
      dy = case_mem[b+5];
      len = case_mem[b+6];
      exp = case_mem[b+7];
      check_equal($sformatf("case %0d node x", c), case_mem[b+1], cur_x);
      check_equal($sformatf("case %0d node y", c), case_mem[b+2], cur_y);
      check_equal($sformatf("case %0d xy port", c), xy_port(cur_x, cur_y, dx, dy), exp);
      exp_out[src] = exp;
      build_packet(src, dx, dy, len);
   endtask

   // one flit per strobe, only into an empty buffer
   task automatic send_packet(input int src, input int len, input int exp, input bit timed);
      for (int k = 0; k < len; k++) begin
         @(negedge clk);
         while (busy[src]) @(negedge clk);
         @(posedge clk);
         in_valid[src] <= 1'b1;
         in_flit[src*FLIT_W +: FLIT_W] <= flit_buf[src][k];
         // capture edge
         @(posedge clk);
         in_valid[src] <= 1'b0;
         if (timed) begin
            @(negedge clk);
            @(negedge clk);
            check_equal("out_valid one cycle after capture", out_valid, 32'(1) << exp);
         end
      end
   endtask

   ////////////////////////////////////////
   // arrival monitor
   ////////////////////////////////////////

   always @(negedge clk) begin : monitor
      logic [FLIT_W-1:0] got;
      logic [NUM_PORTS-1:0] delivered;
      int s;
      delivered = '0;
      if (rst) begin
         prev_busy = '0;
      end else begin
         for (int o = 0; o < NUM_PORTS; o++) begin
            if (out_valid[o]) begin
               got = out_flit[o*FLIT_W +: FLIT_W];
               // idle output, must be the header of a pending packet
               if (active[o] < 0) begin
                  for (int i = 0; i < NUM_PORTS; i++) begin
                     if (active[o] < 0 && exp_out[i] == o && rd_cnt[i] < wr_cnt[i]
                         && flit_buf[i][rd_cnt[i]] == got) begin
                        active[o] = i;
                     end
                  end
               end
               s = active[o];
               if (s < 0) begin
                  err_cnt++;
                  $display("unexpected flit %h on output %0d at %0t ns", got, o, $time);
               end else begin
                  check_equal($sformatf("flit on output %0d", o), got, flit_buf[s][rd_cnt[s]]);
                  rd_cnt[s]++;
                  delivered[s] = 1'b1;
                  if (rd_cnt[s] == wr_cnt[s]) active[o] = -1;
               end
            end
         end
         // busy falls only when that input's flit went out
         for (int i = 0; i < NUM_PORTS; i++) begin
            if (prev_busy[i] && !busy[i]) begin
               check_equal($sformatf("busy drop on input %0d", i), delivered[i], 1);
            end
         end
         prev_busy = busy;
      end
   end

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////

   initial begin : main
      int n_cases;
      int n_flits;
      int c;
      int s0, s1, l0, l1, e0, e1;
      logic [7:0] op;
      clk = 1'b0;
      rst = 1'b1;
      cfg_wr = 1'b0;
      cfg_x = '0;
      cfg_y = '0;
      in_valid = '0;
      in_flit = '0;
      prev_busy = '0;
      check_cnt = 0;
      err_cnt = 0;
      cycle_cnt = 0;
      for (int i = 0; i < NUM_PORTS; i++) begin
         active[i] = -1;
         rd_cnt[i] = 0;
         wr_cnt[i] = 0;
         exp_out[i] = 0;
      end
      $readmemh("router_cases.txt", case_mem);
      // ff in the op column ends the list
      n_cases = 0;
      n_flits = 0;
      while (n_cases < MAX_CASES && case_mem[n_cases*COLS] != 8'hff) begin
         n_flits += case_mem[n_cases*COLS+6];
         n_cases++;
      end
      cycle_limit = 200 + n_cases * 40 + n_flits * 8;
      if (n_cases == 0) begin
         err_cnt++;
         $display("no cases read from router_cases.txt");
      end
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      cur_x = RST_X;
      cur_y = RST_Y;
      c = 0;
      while (c < n_cases) begin
         op = case_mem[c*COLS];
         if (op[0]) apply_reset();
         if (op[1]) write_addr(case_mem[c*COLS+1], case_mem[c*COLS+2]);
         prepare_case(c, s0, l0, e0);
         if (op[2]) begin
            // two sources at once, same output
            prepare_case(c + 1, s1, l1, e1);
            fork
               send_packet(s0, l0, e0, 1'b0);
               send_packet(s1, l1, e1, 1'b0);
            join
            c += 2;
         end else begin
            send_packet(s0, l0, e0, l0 == 1);
            c += 1;
         end
         while (pending()) @(negedge clk);
      end
      repeat (3) @(posedge clk);
      $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* router_cases.txt */
// op nx ny src dx dy len exp   hex, one case per line, ports L0 E1 N2 W3 S4
// op bit0 reset first, bit1 write node address, bit2 sent together with next line
01 01 02 00 03 02 01 01
01 01 02 01 00 00 01 03
01 01 02 02 01 03 01 04
01 01 02 03 01 00 01 02
01 01 02 04 01 02 01 00
03 00 00 00 02 01 01 01
03 03 01 00 02 01 01 03
03 02 03 02 02 01 01 02
03 02 01 01 02 01 01 00
03 02 00 03 02 01 01 04
03 01 01 04 03 03 05 01
00 01 01 01 01 00 04 02
02 03 03 00 00 03 06 03
04 03 03 01 03 00 05 02
00 03 03 04 03 01 04 02
06 00 02 02 00 02 03 00
00 00 02 03 00 02 06 00
01 01 02 00 00 02 03 03
ff ff ff ff ff ff ff ff

/* compile.f */
noc_mesh_pkg.sv
noc_flit_pkg.sv
flit_lane_if.sv
node_addr_reg.sv
route_compute.sv
input_port.sv
output_switch.sv
router_top.sv
router_assertions.sv
tb_router.sv

/* run_sim.sh */
#!/bin/sh
# build and run the router testbench with verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_router -f compile.f -o tb_router_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_router_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
   exit 1
fi
exit 0
